/* source/mem_isa_pkg.sv */
// ISA-level word types, memory operation and exception cause enums, exception record, store test
package mem_isa_pkg;

    ////////////////////
    // Word types
    ////////////////////

    typedef logic [63:0] xlen_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t; // Destination register index
    typedef logic [5:0]  rob_tag_t;  // Reorder-buffer tag

    ////////////////////
    // Operations
    ////////////////////

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LD  = 4'd3,
        LBU = 4'd4,
        LHU = 4'd5,
        LWU = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SD  = 4'd10
    } mem_op_e;

    // Privileged-spec mcause codes for data accesses
    typedef enum logic [5:0] {
        LD_ADDR_MISALIGNED = 6'd4,
        LD_ACCESS_FAULT    = 6'd5,
        ST_ADDR_MISALIGNED = 6'd6,
        ST_ACCESS_FAULT    = 6'd7
    } xcpt_cause_e;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        xlen_t       origin; // Faulting address
    } xcpt_t;

    function automatic logic is_store(mem_op_e op);
        return (op == SB) || (op == SH) || (op == SW) || (op == SD);
    endfunction

endpackage

/* source/mem_bus_pkg.sv */
// Packed records for the incoming instruction, queue entry, cache request and response, writeback
package mem_bus_pkg;

    import mem_isa_pkg::*;

    ////////////////////
    // Issue side
    ////////////////////

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        reg_addr_t rd;
        xlen_t     imm;
        rob_tag_t  tag;
        xcpt_t     ex;    // Exception raised by earlier stages
    } mem_instr_t;

    typedef struct packed {
        mem_instr_t instr;
        xlen_t      rs1;  // Base address
        xlen_t      rs2;  // Store data
    } lsq_entry_t;

    ////////////////////
    // Data cache
    ////////////////////

    typedef struct packed {
        logic      valid;
        logic      kill;
        mem_op_e   op;
        xlen_t     rs1;
        xlen_t     rs2;
        xlen_t     imm;
        reg_addr_t rd;
    } dcache_req_t;

    typedef struct packed {
        logic  lock;    // Request not taken yet
        xlen_t data;
        xlen_t addr;    // Effective address rs1 + imm
        logic  xcpt_ma; // Misaligned access
        logic  xcpt_pf; // Page or access fault
    } dcache_resp_t;

    ////////////////////
    // Writeback
    ////////////////////

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        rob_tag_t  tag;
        logic      regfile_we;
        xlen_t     result;
        xcpt_t     ex;
    } mem_wb_t;

endpackage

/* source/load_store_queue.sv */
// Load/store queue: show-ahead circular FIFO of memory instructions with their operands
module load_store_queue #(
    parameter int LSQ_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   clear_i,      // Kill or flush
    input  mem_bus_pkg::lsq_entry_t push_entry_i,
    input  logic                   pop_i,
    output mem_bus_pkg::lsq_entry_t head_o,
    output logic                   head_valid_o,
    output logic                   full_o
);

    import mem_bus_pkg::*;

    localparam int PTR_W = (LSQ_DEPTH > 1) ? $clog2(LSQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(LSQ_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    lsq_entry_t mem_q [LSQ_DEPTH];
    ptr_t       rd_ptr_q;
    ptr_t       wr_ptr_q;
    cnt_t       count_q;
    logic       push_en;
    logic       pop_en;

    assign full_o       = (count_q == cnt_t'(LSQ_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem_q[rd_ptr_q]; // Show-ahead read

    assign push_en = push_entry_i.instr.valid & ~full_o; // Dropped while full
    assign pop_en  = pop_i & head_valid_o;

    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(LSQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(LSQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_en && !pop_en) begin
                count_q <= count_q + 1'b1;
            end else if (!push_en && pop_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Issue stage must respect lock_o
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_entry_i.instr.valid |-> !full_o)
        else $error("instruction offered while queue full, dropped");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> head_valid_o)
        else $error("pop from empty queue");

endmodule

/* source/mem_issue_fsm.sv */
// Issue FSM: head issue, held request, commit gating of stores and writeback assembly
module mem_issue_fsm (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     kill_i,
    input  logic                     commit_store_i,
    input  mem_bus_pkg::lsq_entry_t   head_i,
    input  logic                     head_valid_i,
    input  mem_bus_pkg::dcache_resp_t dcache_resp_i,
    input  mem_isa_pkg::xcpt_t        load_xcpt_i,
    output logic                     pop_o,
    output mem_bus_pkg::lsq_entry_t   held_o,
    output logic                     done_o,
    output mem_bus_pkg::dcache_req_t  dcache_req_o,
    output mem_bus_pkg::mem_wb_t      wb_o,
    output logic                     commit_stall_o
);

    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        ISSUE,
        WAIT_RESP,
        WAIT_COMMIT
    } state_e;

    state_e     state_q;
    state_e     state_d;
    lsq_entry_t held_q;
    lsq_entry_t req_src;
    logic       held_store;

    assign held_o     = held_q;
    assign held_store = is_store(held_q.instr.op);

    ////////////////////
    // State and capture
    ////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ISSUE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            held_q <= head_i; // Entry stays here until completion
        end
    end

    always_comb begin
        state_d = state_q;
        if (kill_i) begin
            state_d = ISSUE;
        end else begin
            unique case (state_q)
                ISSUE: begin
                    if (head_valid_i) begin
                        state_d = is_store(head_i.instr.op) ? WAIT_COMMIT : WAIT_RESP;
                    end
                end
                WAIT_COMMIT: begin
                    if (commit_store_i) begin
                        state_d = WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (!dcache_resp_i.lock) begin
                        state_d = ISSUE;
                    end
                end
                default: state_d = ISSUE;
            endcase
        end
    end

    ////////////////////
    // Cache request
    ////////////////////

    assign pop_o   = (state_q == ISSUE) & head_valid_i & ~kill_i;
    assign req_src = (state_q == ISSUE) ? head_i : held_q; // Head only in the issue cycle

    always_comb begin
        unique case (state_q)
            ISSUE:       dcache_req_o.valid = pop_o & ~is_store(head_i.instr.op);
            WAIT_COMMIT: dcache_req_o.valid = commit_store_i & ~kill_i;
            WAIT_RESP:   dcache_req_o.valid = ~kill_i;
            default:     dcache_req_o.valid = 1'b0;
        endcase
    end

    assign dcache_req_o.kill = kill_i;
    assign dcache_req_o.op   = req_src.instr.op;
    assign dcache_req_o.rs1  = req_src.rs1;
    assign dcache_req_o.rs2  = req_src.rs2;
    assign dcache_req_o.imm  = req_src.instr.imm;
    assign dcache_req_o.rd   = req_src.instr.rd;

    assign done_o         = (state_q == WAIT_RESP) & ~dcache_resp_i.lock & ~kill_i;
    assign commit_stall_o = (state_q == WAIT_RESP) & commit_store_i & held_store
                            & dcache_resp_i.lock;

    ////////////////////
    // Writeback
    ////////////////////

    assign wb_o.valid      = done_o;
    assign wb_o.rd         = held_q.instr.rd;
    assign wb_o.tag        = held_q.instr.tag;
    assign wb_o.regfile_we = ~held_store;
    assign wb_o.result     = held_store ? xlen_t'(0) : dcache_resp_i.data;
    assign wb_o.ex         = load_xcpt_i;

    // Cache sees one unchanged request until it drops lock
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (dcache_req_o.valid && dcache_resp_i.lock) |=>
        (kill_i || (dcache_req_o.valid && $stable(dcache_req_o.op) && $stable(dcache_req_o.rs1)
                    && $stable(dcache_req_o.rs2) && $stable(dcache_req_o.imm)
                    && $stable(dcache_req_o.rd))))
        else $error("request changed while cache locked");

endmodule

/* source/mem_xcpt_check.sv */
// Completion exception check: preset, misaligned, fault and non-canonical address, by priority
module mem_xcpt_check #(
    parameter int VA_BITS = 40
) (
    input  mem_bus_pkg::lsq_entry_t   held_i,
    input  logic                     done_i,
    input  mem_bus_pkg::dcache_resp_t dcache_resp_i,
    output mem_isa_pkg::xcpt_t        load_xcpt_o,
    output mem_isa_pkg::xcpt_t        commit_xcpt_o
);

    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int UPPER_W = 64 - VA_BITS + 1;

    logic [UPPER_W-1:0] va_upper;
    logic               non_canon;
    logic               st_op;
    xcpt_t              resp_xcpt;

    // Upper bits must all copy the top valid VA bit
    assign va_upper  = dcache_resp_i.addr[63:VA_BITS-1];
    assign non_canon = ~((&va_upper) | ~(|va_upper));
    assign st_op     = is_store(held_i.instr.op);

    always_comb begin
        resp_xcpt.valid  = dcache_resp_i.xcpt_ma | dcache_resp_i.xcpt_pf | non_canon;
        resp_xcpt.origin = dcache_resp_i.addr;
        if (dcache_resp_i.xcpt_ma) begin
            resp_xcpt.cause = st_op ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
        end else begin
            resp_xcpt.cause = st_op ? ST_ACCESS_FAULT : LD_ACCESS_FAULT; // Fault or non-canonical
        end
    end

    ////////////////////
    // Routing
    ////////////////////

    always_comb begin
        load_xcpt_o   = '0;
        commit_xcpt_o = '0;
        if (done_i) begin
            if (held_i.instr.ex.valid) begin
                load_xcpt_o = held_i.instr.ex; // Earlier stage wins
            end else if (st_op) begin
                commit_xcpt_o = resp_xcpt;
            end else begin
                load_xcpt_o = resp_xcpt;
            end
        end
    end

    // One completion reports at most one exception
    always_comb begin
        a_one_xcpt: assert (!(load_xcpt_o.valid && commit_xcpt_o.valid))
            else $error("exception on both writeback and commit");
    end

endmodule

/* source/mem_unit.sv */
// Memory unit top: load/store queue, issue FSM and exception check
module mem_unit #(
    parameter int LSQ_DEPTH = 4,
    parameter int VA_BITS   = 40
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     kill_i,         // Abort everything
    input  logic                     flush_i,        // Empty the queue only
    input  mem_bus_pkg::mem_instr_t   instr_i,
    input  mem_isa_pkg::xlen_t        rs1_i,
    input  mem_isa_pkg::xlen_t        rs2_i,
    input  logic                     commit_store_i, // Store may go to cache
    input  mem_bus_pkg::dcache_resp_t dcache_resp_i,
    output mem_bus_pkg::dcache_req_t  dcache_req_o,
    output mem_bus_pkg::mem_wb_t      wb_o,
    output mem_isa_pkg::xcpt_t        commit_xcpt_o,
    output logic                     commit_stall_o,
    output logic                     lock_o          // Queue full
);

    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    logic       lsq_clear;
    lsq_entry_t push_entry;
    lsq_entry_t head;
    logic       head_valid;
    logic       pop;
    lsq_entry_t held;
    logic       done;
    xcpt_t      load_xcpt;

    assign lsq_clear        = kill_i | flush_i;
    assign push_entry.instr = instr_i;
    assign push_entry.rs1   = rs1_i;
    assign push_entry.rs2   = rs2_i;

    load_store_queue #(
        .LSQ_DEPTH(LSQ_DEPTH)
    ) u_lsq (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clear_i     (lsq_clear),
        .push_entry_i(push_entry),
        .pop_i       (pop),
        .head_o      (head),
        .head_valid_o(head_valid),
        .full_o      (lock_o)
    );

    mem_issue_fsm u_fsm (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .kill_i        (kill_i),
        .commit_store_i(commit_store_i),
        .head_i        (head),
        .head_valid_i  (head_valid),
        .dcache_resp_i (dcache_resp_i),
        .load_xcpt_i   (load_xcpt),
        .pop_o         (pop),
        .held_o        (held),
        .done_o        (done),
        .dcache_req_o  (dcache_req_o),
        .wb_o          (wb_o),
        .commit_stall_o(commit_stall_o)
    );

    mem_xcpt_check #(
        .VA_BITS(VA_BITS)
    ) u_xcpt (
        .held_i       (held),
        .done_i       (done),
        .dcache_resp_i(dcache_resp_i),
        .load_xcpt_o  (load_xcpt),
        .commit_xcpt_o(commit_xcpt_o)
    );

endmodule

/* dv/mem_unit_tb.sv */
// Memory unit testbench: clock, reset, cache model, stimulus table, checks and final report
module mem_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int    LSQ_DEPTH    = 4;
    localparam int    VA_BITS      = 40;
    localparam int    WB_TIMEOUT   = 200;
    localparam int    NUM_ROWS     = 14;
    localparam xlen_t DATA_PATTERN = 64'h5a5a_0000_0000_a5a5;
    localparam logic [31:0] FAULT_HI = 32'h0000_00f0; // Upper half of the fault region

    typedef struct packed {
        mem_op_e    op;
        xlen_t      rs1;
        xlen_t      rs2;
        xlen_t      imm;
        reg_addr_t  rd;
        rob_tag_t   tag;
        xcpt_t      ex;         // Preset from earlier stages
        logic [3:0] commit_dly; // Cycles in WAIT_COMMIT before commit
        logic [3:0] hold;       // Cycles the cache is forced locked after commit
        logic [5:0] exp_cause;  // Zero when no exception
    } row_t;

    localparam xcpt_t NO_EX  = '0;
    localparam xcpt_t PRESET = '{1'b1, LD_ACCESS_FAULT, 64'h0000_0000_dead_0000};

    row_t rows [NUM_ROWS] = '{
        '{LD,  64'h1000, 64'h0, 64'h8, 5'd1, 6'd1, NO_EX, 4'd0, 4'd0, 6'd0},
        '{LW,  64'h2000, 64'h0, 64'h4, 5'd2, 6'd2, NO_EX, 4'd0, 4'd0, 6'd0},
        '{LBU, 64'h3001, 64'h0, 64'h2, 5'd3, 6'd3, NO_EX, 4'd0, 4'd0, 6'd0},
        '{LH,  64'hffff_ffff_ffff_f000, 64'h0, 64'h2, 5'd4, 6'd4, NO_EX, 4'd0, 4'd0, 6'd0},
        '{SD,  64'h4000, 64'h1234_5678, 64'h10, 5'd5, 6'd5, NO_EX, 4'd3, 4'd3, 6'd0},
        '{SW,  64'h4100, 64'h55aa, 64'h0, 5'd6, 6'd6, NO_EX, 4'd0, 4'd0, 6'd0},
        '{LW,  64'h5002, 64'h0, 64'h0, 5'd7, 6'd7, NO_EX, 4'd0, 4'd0, 6'd4},
        '{SD,  64'h5004, 64'h77, 64'h0, 5'd8, 6'd8, NO_EX, 4'd1, 4'd0, 6'd6},
        '{LD,  64'h0000_00f0_0000_1000, 64'h0, 64'h0, 5'd9, 6'd9, NO_EX, 4'd0, 4'd0, 6'd5},
        '{SB,  64'h0000_00f0_0000_2000, 64'h1, 64'h0, 5'd10, 6'd10, NO_EX, 4'd0, 4'd0, 6'd7},
        '{LD,  64'h0000_0100_0000_0000, 64'h0, 64'h0, 5'd11, 6'd11, NO_EX, 4'd0, 4'd0, 6'd5},
        '{SH,  64'h8000_0000_0000_0000, 64'h2, 64'h0, 5'd12, 6'd12, NO_EX, 4'd0, 4'd0, 6'd7},
        '{LW,  64'h6001, 64'h0, 64'h0, 5'd13, 6'd13, PRESET, 4'd0, 4'd0, 6'd5},
        '{LD,  64'h7000, 64'h0, 64'h18, 5'd14, 6'd14, NO_EX, 4'd0, 4'd0, 6'd0}
    };

    logic         clk_i;
    logic         rstn_i;
    logic         kill_i;
    logic         flush_i;
    mem_instr_t   instr_i;
    xlen_t        rs1_i;
    xlen_t        rs2_i;
    logic         commit_store_i;
    dcache_resp_t dcache_resp_i;
    dcache_req_t  dcache_req_o;
    mem_wb_t      wb_o;
    xcpt_t        commit_xcpt_o;
    logic         commit_stall_o;
    logic         lock_o;

    logic   cache_lock;
    logic   lock_force;
    logic   lock_rand;
    xlen_t  resp_addr;
    integer seed     = 32'ha628_baaa;
    int     checks   = 0;
    int     errors   = 0;
    int     timeouts = 0;

    mem_unit #(
        .LSQ_DEPTH(LSQ_DEPTH),
        .VA_BITS  (VA_BITS)
    ) uut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .kill_i        (kill_i),
        .flush_i       (flush_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .commit_store_i(commit_store_i),
        .dcache_resp_i (dcache_resp_i),
        .dcache_req_o  (dcache_req_o),
        .wb_o          (wb_o),
        .commit_xcpt_o (commit_xcpt_o),
        .commit_stall_o(commit_stall_o),
        .lock_o        (lock_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////
    // Cache model
    ////////////////////

    function automatic xlen_t access_size(mem_op_e op);
        case (op)
            LB, LBU, SB: return 64'd1;
            LH, LHU, SH: return 64'd2;
            LW, LWU, SW: return 64'd4;
            default:     return 64'd8;
        endcase
    endfunction

    always_comb begin
        resp_addr             = dcache_req_o.rs1 + dcache_req_o.imm;
        dcache_resp_i.lock    = cache_lock;
        dcache_resp_i.addr    = resp_addr;
        dcache_resp_i.data    = resp_addr ^ DATA_PATTERN;
        dcache_resp_i.xcpt_ma = (resp_addr & (access_size(dcache_req_o.op) - 64'd1)) != 64'd0;
        dcache_resp_i.xcpt_pf = (resp_addr[63:32] == FAULT_HI);
    end

    // Next cycle, inputs driven just after the edge; lock drawn here
    task automatic step();
        int rnd;
        @(posedge clk_i);
        #0.5;
        rnd        = $random(seed);
        cache_lock = lock_force || (lock_rand && rnd[0]);
    endtask

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_val(input string tname, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_xcpt(input string tname, input xcpt_t exp, input xcpt_t act);
        check_val({tname, " valid"}, 64'(exp.valid), 64'(act.valid));
        if (exp.valid && act.valid) begin
            check_val({tname, " cause"}, 64'(exp.cause), 64'(act.cause));
            check_val({tname, " origin"}, exp.origin, act.origin);
        end
    endtask

    function automatic row_t mk_load(xlen_t rs1, int idx);
        row_t r;
        r     = '0;
        r.op  = LD;
        r.rs1 = rs1;
        r.rd  = reg_addr_t'(idx);
        r.tag = rob_tag_t'(idx);
        return r;
    endfunction

    task automatic drive_instr(input row_t r);
        instr_i.valid = 1'b1;
        instr_i.op    = r.op;
        instr_i.rd    = r.rd;
        instr_i.imm   = r.imm;
        instr_i.tag   = r.tag;
        instr_i.ex    = r.ex;
        rs1_i         = r.rs1;
        rs2_i         = r.rs2;
    endtask

    // Stall rule for a store: low in the commit cycle, then equal to lock
    task automatic wait_wb(input string tname, input logic chk_stall, input int hold,
                           output logic got, output logic stall_seen);
        int   cyc;
        logic exp_stall;
        got        = 1'b0;
        stall_seen = 1'b0;
        cyc        = 0;
        while (!got && cyc < WB_TIMEOUT) begin
            @(negedge clk_i);
            if (chk_stall) begin
                exp_stall = (cyc > 0) && cache_lock;
                check_val({tname, " commit_stall"}, 64'(exp_stall), 64'(commit_stall_o));
                stall_seen = stall_seen | commit_stall_o;
            end
            if (wb_o.valid) begin
                got = 1'b1;
            end else begin
                if (cyc >= hold) begin
                    lock_force = 1'b0;
                end
                step();
                cyc++;
            end
        end
        if (!got) begin
            timeouts++;
            $display("%s: no writeback within %0d cycles", tname, WB_TIMEOUT);
        end
    endtask

    task automatic check_completion(input string tname, input row_t r);
        xlen_t addr;
        logic  st;
        xcpt_t exp_wb;
        xcpt_t exp_cm;
        addr   = r.rs1 + r.imm;
        st     = r.op inside {SB, SH, SW, SD};
        exp_wb = '0;
        exp_cm = '0;
        if (r.ex.valid) begin
            exp_wb = r.ex; // Preset wins over any response flag
        end else if (r.exp_cause != 6'd0 && st) begin
            exp_cm = '{1'b1, xcpt_cause_e'(r.exp_cause), addr};
        end else if (r.exp_cause != 6'd0) begin
            exp_wb = '{1'b1, xcpt_cause_e'(r.exp_cause), addr};
        end
        check_val({tname, " req op"}, 64'(r.op), 64'(dcache_req_o.op));
        check_val({tname, " req rd"}, 64'(r.rd), 64'(dcache_req_o.rd));
        check_val({tname, " req rs2"}, r.rs2, dcache_req_o.rs2); // Store data
        check_val({tname, " rd"}, 64'(r.rd), 64'(wb_o.rd));
        check_val({tname, " tag"}, 64'(r.tag), 64'(wb_o.tag));
        check_val({tname, " regfile_we"}, 64'(!st), 64'(wb_o.regfile_we));
        check_val({tname, " result"}, st ? 64'h0 : (addr ^ DATA_PATTERN), wb_o.result);
        check_xcpt({tname, " wb ex"}, exp_wb, wb_o.ex);
        check_xcpt({tname, " commit ex"}, exp_cm, commit_xcpt_o);
    endtask

    task automatic expect_quiet(input string tname, input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            if (wb_o.valid) begin
                errors++;
                $display("%s: unexpected writeback of rd %0d", tname, wb_o.rd);
            end
            step();
        end
    endtask

    task automatic run_row(input int i);
        row_t  r;
        string tname;
        logic  st;
        logic  got;
        logic  stall_seen;
        r     = rows[i];
        tname = $sformatf("row %0d %s", i, r.op.name());
        st    = r.op inside {SB, SH, SW, SD};
        step();
        drive_instr(r);
        lock_force = (r.hold != 4'd0);
        step();
        instr_i.valid = 1'b0;
        if (st) begin
            for (int d = 0; d <= int'(r.commit_dly); d++) begin
                @(negedge clk_i);
                check_val({tname, " early request"}, 64'h0, 64'(dcache_req_o.valid));
                step();
            end
            commit_store_i = 1'b1;
        end
        wait_wb(tname, st, int'(r.hold), got, stall_seen);
        if (got) begin
            check_completion(tname, r);
        end
        if (st && r.hold != 4'd0 && !stall_seen) begin
            errors++;
            $display("%s: commit_stall_o never rose while the cache was locked", tname);
        end
        step();
        commit_store_i = 1'b0;
        lock_force     = 1'b0;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int   accepted;
        int   cyc;
        logic got;
        logic stall_seen;
        row_t r;
        row_t pend [$];
        rstn_i         = 1'b0;
        kill_i         = 1'b0;
        flush_i        = 1'b0;
        instr_i        = '0;
        rs1_i          = '0;
        rs2_i          = '0;
        commit_store_i = 1'b0;
        cache_lock     = 1'b0;
        lock_force     = 1'b0;
        lock_rand      = 1'b0;
        repeat (16) @(posedge clk_i);
        #0.5;
        rstn_i = 1'b1;
        @(negedge clk_i);
        check_val("reset req valid", 64'h0, 64'(dcache_req_o.valid));
        check_val("reset wb valid", 64'h0, 64'(wb_o.valid));
        check_val("reset commit ex", 64'h0, 64'(commit_xcpt_o.valid));
        check_val("reset commit_stall", 64'h0, 64'(commit_stall_o));
        check_val("reset lock_o", 64'h0, 64'(lock_o));

        lock_rand = 1'b1; // Random cache lock for the table
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        lock_rand = 1'b0;

        // Store parked in WAIT_COMMIT, cache locked, queue fills up
        lock_force = 1'b1;
        step();
        drive_instr(rows[5]);
        step();
        instr_i.valid = 1'b0;
        step();
        step();
        accepted = 0;
        while (!lock_o && accepted < 2 * LSQ_DEPTH) begin
            r = mk_load(64'h9000 + 64'(8 * accepted), 16 + accepted);
            drive_instr(r);
            pend.push_back(r);
            step();
            accepted++;
        end
        instr_i.valid = 1'b0;
        check_val("backpressure accepted", 64'(LSQ_DEPTH), 64'(accepted));
        commit_store_i = 1'b1;
        wait_wb("backpressure store", 1'b1, 0, got, stall_seen);
        if (got) begin
            check_completion("backpressure store", rows[5]);
        end
        step();
        commit_store_i = 1'b0;
        lock_force     = 1'b1; // Keeps the next load from finishing early
        cyc = 0;
        while (lock_o && cyc < WB_TIMEOUT) begin
            step();
            cyc++;
        end
        if (lock_o) begin
            timeouts++;
            $display("lock_o stayed high after the store completed");
        end
        lock_force = 1'b0;
        while (pend.size() > 0) begin
            r = pend.pop_front();
            wait_wb($sformatf("backpressure rd %0d", r.rd), 1'b0, 0, got, stall_seen);
            if (got) begin
                check_completion($sformatf("backpressure rd %0d", r.rd), r);
            end
            step();
        end

        // Kill with one load in flight and two queued
        lock_force = 1'b1;
        drive_instr(mk_load(64'ha000, 24));
        step();
        drive_instr(mk_load(64'ha008, 25));
        step();
        drive_instr(mk_load(64'ha010, 26));
        step();
        instr_i.valid = 1'b0;
        lock_force    = 1'b0; // Response ready in the kill cycle
        step();
        kill_i = 1'b1;
        @(negedge clk_i);
        check_val("kill req kill", 64'h1, 64'(dcache_req_o.kill));
        check_val("kill wb valid", 64'h0, 64'(wb_o.valid));
        step();
        kill_i = 1'b0;
        expect_quiet("kill", 12);
        r = mk_load(64'ha100, 27);
        drive_instr(r);
        step();
        instr_i.valid = 1'b0;
        wait_wb("after kill", 1'b0, 0, got, stall_seen);
        if (got) begin
            check_completion("after kill", r);
        end
        step();

        // Flush keeps the held load, drops the queued ones
        lock_force = 1'b1;
        r = mk_load(64'hb000, 28);
        drive_instr(r);
        step();
        drive_instr(mk_load(64'hb008, 29));
        step();
        drive_instr(mk_load(64'hb010, 30));
        step();
        instr_i.valid = 1'b0;
        step();
        flush_i = 1'b1;
        step();
        flush_i    = 1'b0;
        lock_force = 1'b0;
        wait_wb("flush held", 1'b0, 0, got, stall_seen);
        if (got) begin
            check_completion("flush held", r);
        end
        step();
        expect_quiet("flush", 12);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
source/mem_isa_pkg.sv
source/mem_bus_pkg.sv
source/load_store_queue.sv
source/mem_issue_fsm.sv
source/mem_xcpt_check.sv
source/mem_unit.sv
dv/mem_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the memory unit testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module mem_unit_tb -f build.f -o mem_unit_sim \
    && ./obj_dir/mem_unit_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
